/* list.f */
logic/tlk_pkg.sv
logic/tlk_credit_fifo.sv
logic/tlk_regs.sv
logic/tlk_tx_framer.sv
logic/tlk_rx_deframer.sv
logic/tlk2711_top.sv
sim/tlk2711_sva.sv
sim/tlk2711_tb.sv

/* sim/tlk2711_tb.sv */
// tlk2711_tb: clock, reset, pin loopback with idle injection, reference frames, checks, timeout
`timescale 1ns/1ps

module tlk2711_tb;

    localparam int N_FRAMES  = 6;   // frames sent over the whole run
    localparam int TIMEOUT   = N_FRAMES * (tlk_pkg::TX_DEPTH + 4 + tlk_pkg::TX_DEPTH) + 500;
    localparam int INJECT_AT = 3;   // payload index replaced by idle
    localparam logic [17:0] IDLE_ENT = {2'b01, tlk_pkg::IDLE_WORD};
    localparam logic [17:0] EOF_ENT  = {2'b11, tlk_pkg::EOF_WORD};

    typedef logic [17:0] tx_ent_t;          // {tkmsb, tklsb, word}
    typedef tx_ent_t     frame_q_t [$];
    typedef logic [15:0] word_q_t [$];

    logic        clk_80, rst_80, i_reg_wen, i_reg_ren, i_tx_valid, i_rx_credit;
    logic [15:0] i_reg_waddr, i_reg_raddr, i_tx_data, i_2711_rxd, o_2711_txd, o_rx_data;
    logic [63:0] i_reg_wdata, o_reg_rdata;
    logic        o_tx_credit, o_rx_valid, o_rx_last, o_tx_irq, o_rx_irq, o_loss_irq;
    logic        i_2711_rkmsb, i_2711_rklsb, o_2711_tkmsb, o_2711_tklsb;
    logic        o_2711_enable, o_2711_loopen, o_2711_lckrefn;

    integer      seed;
    int          err_cnt, checks, cycles, tx_sent, tx_returned, tx_eof_seen, rx_seen, lb_idx;
    int          len;
    logic        mon_on = 1'b0;
    logic        inject_en = 1'b0;
    logic        prev_eof = 1'b0;
    tx_ent_t     exp_tx [$];
    logic [16:0] exp_rx [$];                // {last, data}

    tlk2711_top DUT (.*);

    initial begin
        clk_80 = 1'b0;
        forever #20 clk_80 = ~clk_80;       // 40 ns
    end

    // expected line words for one frame
    function automatic frame_q_t build_frame(word_q_t payload);
        frame_q_t f;
        f.push_back({2'b11, tlk_pkg::SOF_WORD});
        foreach (payload[i]) f.push_back({2'b00, payload[i]});   // data, no k
        f.push_back(EOF_ENT);
        return f;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [63:0] data);
        @(posedge clk_80);
        i_reg_wen   <= 1'b1;
        i_reg_waddr <= addr;
        i_reg_wdata <= data;
        @(posedge clk_80);
        i_reg_wen   <= 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [63:0] data);
        @(posedge clk_80);
        i_reg_ren   <= 1'b1;
        i_reg_raddr <= addr;
        @(posedge clk_80);
        i_reg_ren   <= 1'b0;
        @(negedge clk_80);
        data = o_reg_rdata;                 // one cycle after the read strobe
    endtask

    task automatic expect_reg(input logic [15:0] addr, input logic [63:0] exp, input string name);
        logic [63:0] data;
        read_reg(addr, data);
        check_val(name, data, exp);
    endtask

    task automatic wait_reg(input logic [15:0] addr, input logic [63:0] value);
        logic [63:0] data;
        read_reg(addr, data);
        while (data !== value) read_reg(addr, data);   // bounded by the timeout
    endtask

    task automatic give_credit();
        @(posedge clk_80);
        i_rx_credit <= 1'b1;
        @(posedge clk_80);
        i_rx_credit <= 1'b0;
    endtask

    // random payload, expectations, then words under tx credits; rx_keep words come back
    task automatic send_frame(input int n, input int rx_keep);
        word_q_t  payload;
        frame_q_t frame;
        int       target;
        target = tx_eof_seen + 1;
        for (int i = 0; i < n; i++) payload.push_back(16'($random(seed)));
        frame = build_frame(payload);
        foreach (frame[i]) exp_tx.push_back(frame[i]);
        for (int i = 0; i < rx_keep; i++)
            exp_rx.push_back({(rx_keep == n && i == n - 1), payload[i]});   // last on clean end
        write_reg(tlk_pkg::ADDR_FRAME_LEN, 64'(n));
        foreach (payload[i]) begin
            @(posedge clk_80);
            while (tlk_pkg::TX_DEPTH - tx_sent + tx_returned == 0) begin
                i_tx_valid <= 1'b0;         // out of credits
                @(posedge clk_80);
            end
            i_tx_valid <= 1'b1;
            i_tx_data  <= payload[i];
            tx_sent++;
        end
        @(posedge clk_80);
        i_tx_valid <= 1'b0;
        while (tx_eof_seen < target) @(posedge clk_80);
    endtask

    // pins carry idle while the link is disabled, one data word swapped when armed
    always @(posedge clk_80) begin
        if (o_2711_tkmsb && o_2711_txd == tlk_pkg::SOF_WORD) lb_idx <= 0;
        else if (!o_2711_tkmsb && !o_2711_tklsb) lb_idx <= lb_idx + 1;
        if (o_2711_enable !== 1'b1 ||
            (inject_en && !o_2711_tkmsb && !o_2711_tklsb && lb_idx == INJECT_AT)) begin
            i_2711_rxd   <= tlk_pkg::IDLE_WORD;
            i_2711_rkmsb <= 1'b0;
            i_2711_rklsb <= 1'b1;
        end else begin
            i_2711_rxd   <= o_2711_txd;
            i_2711_rkmsb <= o_2711_tkmsb;
            i_2711_rklsb <= o_2711_tklsb;
        end
    end

    // compare txd and host rx words against the queues
    always @(negedge clk_80) begin
        tx_ent_t cur;
        cur = {o_2711_tkmsb, o_2711_tklsb, o_2711_txd};
        if (mon_on) begin
            if (o_tx_credit) tx_returned++;
            if (cur != IDLE_ENT) begin
                if (exp_tx.size() == 0) begin
                    $display("unexpected word %h on o_2711_txd", o_2711_txd);
                    err_cnt++;
                end else check_val("o_2711_txd", cur, exp_tx.pop_front());
            end
            if (prev_eof && cur != IDLE_ENT) begin
                $display("end word not followed by an idle word");
                err_cnt++;
            end
            prev_eof = (cur == EOF_ENT);
            if (cur == EOF_ENT) tx_eof_seen++;
            if (o_rx_valid) begin
                rx_seen++;
                if (exp_rx.size() == 0) begin
                    $display("o_rx_valid with no word expected");
                    err_cnt++;
                end else check_val("o_rx_last/o_rx_data", {o_rx_last, o_rx_data},
                                   exp_rx.pop_front());
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk_80);
            cycles++;
        end
        $display("run stopped, no finish within %0d cycles", TIMEOUT);
        $display("checks %0d, errors %0d", checks, err_cnt);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        seed         = 74540;
        rst_80       = 1'b1;
        i_reg_wen    = 1'b0;
        i_reg_waddr  = '0;
        i_reg_wdata  = '0;
        i_reg_ren    = 1'b0;
        i_reg_raddr  = '0;
        i_tx_valid   = 1'b0;
        i_tx_data    = '0;
        i_rx_credit  = 1'b0;
        i_2711_rxd   = tlk_pkg::IDLE_WORD;
        i_2711_rkmsb = 1'b0;
        i_2711_rklsb = 1'b1;
        repeat (4) @(posedge clk_80);
        rst_80 <= 1'b0;
        @(posedge clk_80);
        @(negedge clk_80);
        // reset state
        check_val("o_tx_irq", o_tx_irq, 0);
        check_val("o_rx_irq", o_rx_irq, 0);
        check_val("o_loss_irq", o_loss_irq, 0);
        check_val("o_rx_valid", o_rx_valid, 0);
        check_val("o_tx_credit", o_tx_credit, 0);
        check_val("o_2711_enable", o_2711_enable, 0);
        check_val("o_2711_loopen", o_2711_loopen, 0);
        check_val("o_2711_lckrefn", o_2711_lckrefn, 1);
        check_val("o_2711_txd", {o_2711_tkmsb, o_2711_tklsb, o_2711_txd}, IDLE_ENT);
        @(posedge clk_80);
        mon_on = 1'b1;
        // every register reads 0 out of reset
        for (int a = 0; a <= 6; a++)
            expect_reg(16'(a), 64'h0, $sformatf("reg %0d", a));
        // register readback
        write_reg(tlk_pkg::ADDR_CTRL, 64'h7);
        expect_reg(tlk_pkg::ADDR_CTRL, 64'h7, "ctrl");
        write_reg(tlk_pkg::ADDR_FRAME_LEN, 64'h5);
        expect_reg(tlk_pkg::ADDR_FRAME_LEN, 64'h5, "frame_len");
        write_reg(tlk_pkg::ADDR_IRQ_MASK, 64'h7);
        expect_reg(tlk_pkg::ADDR_IRQ_MASK, 64'h7, "irq_mask");
        expect_reg(16'h0007, 64'h0, "unmapped 0007");
        expect_reg(16'hbeef, 64'h0, "unmapped beef");
        check_val("o_2711_enable", o_2711_enable, 1);
        check_val("o_2711_loopen", o_2711_loopen, 1);
        check_val("o_2711_lckrefn", o_2711_lckrefn, 0);
        // transmit, frame length 5, rx credits withheld
        send_frame(5, 5);
        check_val("o_tx_credit pulses", tx_returned, 5);
        expect_reg(tlk_pkg::ADDR_TX_FRAMES, 64'h1, "tx_frames");
        check_val("o_tx_irq", o_tx_irq, 1);
        write_reg(tlk_pkg::ADDR_IRQ_STATUS, 64'h1);
        @(negedge clk_80);
        check_val("o_tx_irq", o_tx_irq, 0);
        // loopback receive, words wait for credits
        wait_reg(tlk_pkg::ADDR_RX_FRAMES, 64'h1);
        check_val("rx words before credit", rx_seen, 0);
        check_val("o_rx_irq", o_rx_irq, 1);
        repeat (5) give_credit();
        while (exp_rx.size() != 0) @(posedge clk_80);
        // three frames of random length
        for (int f = 0; f < 3; f++) begin
            len = ($unsigned($random(seed)) % tlk_pkg::TX_DEPTH) + 1;
            while (exp_rx.size() + len > tlk_pkg::RX_DEPTH) give_credit();   // room in rx buffer
            send_frame(len, len);
        end
        while (exp_rx.size() != 0) give_credit();
        expect_reg(tlk_pkg::ADDR_TX_FRAMES, 64'h4, "tx_frames");
        expect_reg(tlk_pkg::ADDR_RX_FRAMES, 64'h4, "rx_frames");
        // idle mid-frame, held word and the rest of the frame lost
        inject_en <= 1'b1;
        send_frame(6, INJECT_AT - 1);
        inject_en <= 1'b0;
        wait_reg(tlk_pkg::ADDR_ERRORS, 64'h1);
        check_val("o_loss_irq", o_loss_irq, 1);
        expect_reg(tlk_pkg::ADDR_RX_FRAMES, 64'h4, "rx_frames");
        send_frame(4, 4);
        while (exp_rx.size() != 0) give_credit();
        expect_reg(tlk_pkg::ADDR_RX_FRAMES, 64'h5, "rx_frames");
        expect_reg(tlk_pkg::ADDR_TX_FRAMES, 64'h6, "tx_frames");
        expect_reg(tlk_pkg::ADDR_ERRORS, 64'h1, "errors");
        if (exp_tx.size() != 0) begin
            $display("%0d words never appeared on o_2711_txd", exp_tx.size());
            err_cnt++;
        end
        $display("checks %0d, errors %0d", checks, err_cnt);
        if (err_cnt == 0) $display("NO ERRORS");
        else $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* sim/tlk2711_sva.sv */
// tlk2711_sva: k flag pairing, host rx credit rule, tx credit quiet in reset, bind
`timescale 1ns/1ps

module tlk2711_sva (
    input logic clk_80,
    input logic rst_80,
    input logic i_rx_credit,
    input logic i_rx_valid,
    input logic i_tx_credit,
    input logic i_tkmsb,
    input logic i_tklsb
);

    logic [7:0] avail;   // host view, credits given minus words taken

    always_ff @(posedge clk_80) begin
        if (rst_80) avail <= '0;
        else avail <= avail + 8'(i_rx_credit) - 8'(i_rx_valid);
    end

    a_k_pair: assert property (@(posedge clk_80) disable iff (rst_80)
        i_tkmsb |-> i_tklsb) else $error("tkmsb set without tklsb");

    a_rx_credit: assert property (@(posedge clk_80) disable iff (rst_80)
        i_rx_valid |-> avail != '0) else $error("o_rx_valid with no host credit");

    a_tx_credit_rst: assert property (@(posedge clk_80)
        rst_80 |=> !i_tx_credit) else $error("o_tx_credit pulse during reset");

endmodule

bind tlk2711_top tlk2711_sva u_sva (.clk_80(clk_80), .rst_80(rst_80),
    .i_rx_credit(i_rx_credit), .i_rx_valid(o_rx_valid), .i_tx_credit(o_tx_credit),
    .i_tkmsb(o_2711_tkmsb), .i_tklsb(o_2711_tklsb));

/* logic/tlk2711_top.sv */
// tlk2711_top: registers, tx and rx buffers, framer and deframer for one tlk2711 link
`timescale 1ns/1ps

module tlk2711_top (
    input  logic                       clk_80,
    input  logic                       rst_80,
    input  logic                       i_reg_wen,
    input  logic [tlk_pkg::REG_AW-1:0] i_reg_waddr,
    input  logic [tlk_pkg::REG_DW-1:0] i_reg_wdata,
    input  logic                       i_reg_ren,
    input  logic [tlk_pkg::REG_AW-1:0] i_reg_raddr,
    output logic [tlk_pkg::REG_DW-1:0] o_reg_rdata,
    input  logic                       i_tx_valid,
    input  logic [tlk_pkg::WORD_W-1:0] i_tx_data,
    output logic                       o_tx_credit,
    input  logic                       i_rx_credit,
    output logic                       o_rx_valid,
    output logic [tlk_pkg::WORD_W-1:0] o_rx_data,
    output logic                       o_rx_last,
    output logic                       o_tx_irq,
    output logic                       o_rx_irq,
    output logic                       o_loss_irq,
    input  logic [tlk_pkg::WORD_W-1:0] i_2711_rxd,   // sampled on clk_80, not rx_clk
    input  logic                       i_2711_rkmsb,
    input  logic                       i_2711_rklsb,
    output logic [tlk_pkg::WORD_W-1:0] o_2711_txd,
    output logic                       o_2711_tkmsb,
    output logic                       o_2711_tklsb,
    output logic                       o_2711_enable,
    output logic                       o_2711_loopen,
    output logic                       o_2711_lckrefn
);

    logic                       link_en, tx_en, tx_pop, tx_done;
    logic [tlk_pkg::CNT_W-1:0]  frame_len, tx_count;
    logic [tlk_pkg::WORD_W-1:0] tx_head;
    logic                       rx_push, rx_pop, rx_done, rx_err, rx_full, rx_empty;
    tlk_pkg::rx_word_t          rx_in, rx_head;

    assign o_2711_enable  = link_en;
    assign o_2711_lckrefn = ~link_en;   // lock to ref once link enabled

    tlk_regs u_regs (.clk_80, .rst_80, .i_reg_wen, .i_reg_waddr, .i_reg_wdata,
        .i_reg_ren, .i_reg_raddr, .i_tx_done(tx_done), .i_rx_done(rx_done), .i_err(rx_err),
        .o_reg_rdata, .o_link_en(link_en), .o_loopen(o_2711_loopen), .o_tx_en(tx_en),
        .o_frame_len(frame_len), .o_tx_irq, .o_rx_irq, .o_loss_irq);

    tlk_credit_fifo #(.payload_t(logic [tlk_pkg::WORD_W-1:0])) u_tx_fifo (.clk_80, .rst_80,
        .i_push(i_tx_valid), .i_data(i_tx_data), .i_pop(tx_pop), .o_data(tx_head),
        .o_count(tx_count), .o_full(), .o_empty(), .o_credit(o_tx_credit));

    tlk_tx_framer u_framer (.clk_80, .rst_80, .i_tx_en(tx_en), .i_frame_len(frame_len),
        .i_count(tx_count), .i_head(tx_head), .o_pop(tx_pop), .o_done(tx_done),
        .o_txd(o_2711_txd), .o_tkmsb(o_2711_tkmsb), .o_tklsb(o_2711_tklsb));

    tlk_rx_deframer u_deframer (.clk_80, .rst_80, .i_rxd(i_2711_rxd), .i_rkmsb(i_2711_rkmsb),
        .i_rklsb(i_2711_rklsb), .i_full(rx_full), .i_host_credit(i_rx_credit),
        .i_buf_empty(rx_empty), .o_push(rx_push), .o_word(rx_in), .o_pop(rx_pop),
        .o_done(rx_done), .o_err(rx_err));

    tlk_credit_fifo #(.payload_t(tlk_pkg::rx_word_t)) u_rx_fifo (.clk_80, .rst_80,
        .i_push(rx_push), .i_data(rx_in), .i_pop(rx_pop), .o_data(rx_head),
        .o_count(), .o_full(rx_full), .o_empty(rx_empty), .o_credit());

    // host delivery, popped head registered with its valid
    always_ff @(posedge clk_80) begin
        o_rx_data <= rx_head.data;
        o_rx_last <= rx_head.last;
        if (rst_80) o_rx_valid <= 1'b0;
        else o_rx_valid <= rx_pop;
    end

endmodule

/* logic/tlk_rx_deframer.sv */
// tlk_rx_deframer: receive word classify, frame tracking, last marking, errors, host credits
`timescale 1ns/1ps

module tlk_rx_deframer (
    input  logic                       clk_80,
    input  logic                       rst_80,
    input  logic [tlk_pkg::WORD_W-1:0] i_rxd,
    input  logic                       i_rkmsb,
    input  logic                       i_rklsb,
    input  logic                       i_full,
    input  logic                       i_host_credit,
    input  logic                       i_buf_empty,
    output logic                       o_push,
    output tlk_pkg::rx_word_t          o_word,
    output logic                       o_pop,
    output logic                       o_done,
    output logic                       o_err
);

    typedef enum logic [1:0] {
        FR_OUT,     // between frames
        FR_IN,      // inside a frame
        FR_DROP     // abandoned frame, wait for eof or sof
    } fr_state_t;

    fr_state_t                   state;
    fr_state_t                   state_n;
    logic [tlk_pkg::WORD_W-1:0]  rxd_q;
    logic                        rkmsb_q;
    logic                        rklsb_q;
    logic [tlk_pkg::WORD_W-1:0]  hold_data;    // data word waiting on its successor
    logic                        hold_valid;
    logic                        take;
    logic                        is_k;
    logic                        is_sof;
    logic                        is_eof;
    logic [tlk_pkg::CRED_W-1:0]  host_cred;

    // classify registered word
    assign is_k   = rkmsb_q | rklsb_q;
    assign is_sof = rkmsb_q & rklsb_q & (rxd_q == tlk_pkg::SOF_WORD);
    assign is_eof = rkmsb_q & rklsb_q & (rxd_q == tlk_pkg::EOF_WORD);

    assign o_word.data = hold_data;

    always_comb begin
        state_n     = state;
        take        = 1'b0;
        o_push      = 1'b0;
        o_word.last = 1'b0;
        o_done      = 1'b0;
        o_err       = 1'b0;
        case (state)
            FR_OUT: begin
                if (is_sof) state_n = FR_IN;
                else if (!is_k || is_eof) begin        // stray data or eof
                    o_err   = 1'b1;
                    state_n = is_eof ? FR_OUT : FR_DROP;
                end
            end
            FR_IN: begin
                if (is_sof) o_err = 1'b1;              // restart, held word lost
                else if (is_eof) begin
                    state_n = FR_OUT;
                    if (hold_valid && i_full) o_err = 1'b1; // overflow on last word
                    else if (hold_valid) begin
                        o_push      = 1'b1;
                        o_word.last = 1'b1;
                        o_done      = 1'b1;
                    end
                end else if (!is_k) begin
                    take = 1'b1;
                    if (hold_valid && i_full) begin    // overflow, drop the rest
                        o_err   = 1'b1;
                        take    = 1'b0;
                        state_n = FR_DROP;
                    end else begin
                        o_push = hold_valid;
                    end
                end else begin                         // idle or unknown k inside frame
                    o_err   = 1'b1;
                    state_n = FR_DROP;
                end
            end
            default: begin
                if (is_sof) state_n = FR_IN;
                else if (is_eof) state_n = FR_OUT;
            end
        endcase
    end

    // pop only against host credits
    assign o_pop = (host_cred != '0) && !i_buf_empty;

    always_ff @(posedge clk_80) begin
        rxd_q <= i_rxd;
        if (take) hold_data <= rxd_q;
        if (rst_80) begin
            rkmsb_q    <= 1'b0;
            rklsb_q    <= 1'b1;     // reads as an idle comma
            state      <= FR_OUT;
            hold_valid <= 1'b0;
            host_cred  <= '0;
        end else begin
            rkmsb_q    <= i_rkmsb;
            rklsb_q    <= i_rklsb;
            state      <= state_n;
            hold_valid <= take;
            host_cred  <= host_cred + tlk_pkg::CRED_W'(i_host_credit)
                                    - tlk_pkg::CRED_W'(o_pop);
        end
    end

endmodule

/* logic/tlk_tx_framer.sv */
// tlk_tx_framer: idle, start, data, end sequencing onto the tlk2711 transmit pins
`timescale 1ns/1ps

module tlk_tx_framer (
    input  logic                       clk_80,
    input  logic                       rst_80,
    input  logic                       i_tx_en,
    input  logic [tlk_pkg::CNT_W-1:0]  i_frame_len,
    input  logic [tlk_pkg::CNT_W-1:0]  i_count,     // words in tx buffer
    input  logic [tlk_pkg::WORD_W-1:0] i_head,
    output logic                       o_pop,
    output logic                       o_done,
    output logic [tlk_pkg::WORD_W-1:0] o_txd,
    output logic                       o_tkmsb,
    output logic                       o_tklsb
);

    // state names the word currently on the line
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_END
    } state_t;

    state_t                     state;
    logic [tlk_pkg::CNT_W-1:0]  left;   // payload words still to pop
    logic                       go;

    // only a whole buffered frame starts
    assign go = i_tx_en && (i_frame_len != '0) && (i_count >= i_frame_len);

    // head is popped in the cycle it is registered onto txd
    assign o_pop = (state == ST_START) || (state == ST_DATA && left != '0);

    always_ff @(posedge clk_80) begin
        if (rst_80) begin
            state   <= ST_IDLE;
            left    <= '0;
            o_done  <= 1'b0;
            o_txd   <= '0;
            o_tkmsb <= 1'b0;
            o_tklsb <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (go) begin
                        o_txd   <= tlk_pkg::SOF_WORD;
                        o_tkmsb <= 1'b1;
                        o_tklsb <= 1'b1;
                        left    <= i_frame_len;
                        state   <= ST_START;
                    end else begin
                        o_txd   <= tlk_pkg::IDLE_WORD;   // comma, lsb k only
                        o_tkmsb <= 1'b0;
                        o_tklsb <= 1'b1;
                    end
                end
                ST_START, ST_DATA: begin
                    if (o_pop) begin
                        o_txd   <= i_head;               // data, no k flags
                        o_tkmsb <= 1'b0;
                        o_tklsb <= 1'b0;
                        left    <= left - 1'b1;
                        state   <= ST_DATA;
                    end else begin
                        o_txd   <= tlk_pkg::EOF_WORD;
                        o_tkmsb <= 1'b1;
                        o_tklsb <= 1'b1;
                        o_done  <= 1'b1;                 // lines up with eof on txd
                        state   <= ST_END;
                    end
                end
                default: begin                            // ST_END, forces one idle
                    o_txd   <= tlk_pkg::IDLE_WORD;
                    o_tkmsb <= 1'b0;
                    o_tklsb <= 1'b1;
                    state   <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* logic/tlk_regs.sv */
// tlk_regs: control, frame length, irq status and mask, frame and error counters
`timescale 1ns/1ps

module tlk_regs (
    input  logic                       clk_80,
    input  logic                       rst_80,
    input  logic                       i_reg_wen,
    input  logic [tlk_pkg::REG_AW-1:0] i_reg_waddr,
    input  logic [tlk_pkg::REG_DW-1:0] i_reg_wdata,
    input  logic                       i_reg_ren,
    input  logic [tlk_pkg::REG_AW-1:0] i_reg_raddr,
    input  logic                       i_tx_done,
    input  logic                       i_rx_done,
    input  logic                       i_err,
    output logic [tlk_pkg::REG_DW-1:0] o_reg_rdata,
    output logic                       o_link_en,
    output logic                       o_loopen,
    output logic                       o_tx_en,
    output logic [tlk_pkg::CNT_W-1:0]  o_frame_len,
    output logic                       o_tx_irq,
    output logic                       o_rx_irq,
    output logic                       o_loss_irq
);

    logic [2:0]  ctrl;
    logic [2:0]  irq_status;
    logic [2:0]  irq_mask;
    logic [2:0]  irq_set;
    logic [2:0]  irq_clr;
    logic [31:0] tx_frames;
    logic [31:0] rx_frames;
    logic [31:0] errors;

    assign o_link_en = ctrl[0];
    assign o_loopen  = ctrl[1];
    assign o_tx_en   = ctrl[2];

    assign irq_set = {i_err, i_rx_done, i_tx_done};
    assign irq_clr = (i_reg_wen && i_reg_waddr == tlk_pkg::ADDR_IRQ_STATUS) ?
                     i_reg_wdata[2:0] : 3'b000;

    // level irqs
    assign o_tx_irq   = irq_status[0] & irq_mask[0];
    assign o_rx_irq   = irq_status[1] & irq_mask[1];
    assign o_loss_irq = irq_status[2] & irq_mask[2];

    always_ff @(posedge clk_80) begin
        if (rst_80) begin
            ctrl        <= '0;
            o_frame_len <= '0;
            irq_status  <= '0;
            irq_mask    <= '0;
            tx_frames   <= '0;
            rx_frames   <= '0;
            errors      <= '0;
            o_reg_rdata <= '0;
        end else begin
            if (i_reg_wen) begin
                case (i_reg_waddr)
                    tlk_pkg::ADDR_CTRL:      ctrl <= i_reg_wdata[2:0];
                    tlk_pkg::ADDR_FRAME_LEN: o_frame_len <= i_reg_wdata[tlk_pkg::CNT_W-1:0];
                    tlk_pkg::ADDR_IRQ_MASK:  irq_mask <= i_reg_wdata[2:0];
                    default: ;                                   // status handled below
                endcase
            end
            irq_status <= (irq_status & ~irq_clr) | irq_set;     // set wins
            if (i_tx_done) tx_frames <= tx_frames + 1'b1;
            if (i_rx_done) rx_frames <= rx_frames + 1'b1;
            if (i_err) errors <= errors + 1'b1;
            if (i_reg_ren) begin                                 // held until next read
                case (i_reg_raddr)
                    tlk_pkg::ADDR_CTRL:       o_reg_rdata <= tlk_pkg::REG_DW'(ctrl);
                    tlk_pkg::ADDR_FRAME_LEN:  o_reg_rdata <= tlk_pkg::REG_DW'(o_frame_len);
                    tlk_pkg::ADDR_IRQ_STATUS: o_reg_rdata <= tlk_pkg::REG_DW'(irq_status);
                    tlk_pkg::ADDR_IRQ_MASK:   o_reg_rdata <= tlk_pkg::REG_DW'(irq_mask);
                    tlk_pkg::ADDR_TX_FRAMES:  o_reg_rdata <= tlk_pkg::REG_DW'(tx_frames);
                    tlk_pkg::ADDR_RX_FRAMES:  o_reg_rdata <= tlk_pkg::REG_DW'(rx_frames);
                    tlk_pkg::ADDR_ERRORS:     o_reg_rdata <= tlk_pkg::REG_DW'(errors);
                    default:                  o_reg_rdata <= '0;
                endcase
            end
        end
    end

endmodule

/* logic/tlk_credit_fifo.sv */
// tlk_credit_fifo: circular buffer with head lookahead, occupancy count and credit pulse
`timescale 1ns/1ps

module tlk_credit_fifo #(
    parameter type payload_t = logic [tlk_pkg::WORD_W-1:0]
) (
    input  logic                     clk_80,
    input  logic                     rst_80,
    input  logic                     i_push,
    input  payload_t                 i_data,
    input  logic                     i_pop,
    output payload_t                 o_data,   // head word, valid when not empty
    output logic [tlk_pkg::CNT_W-1:0] o_count,
    output logic                     o_full,
    output logic                     o_empty,
    output logic                     o_credit  // one pulse per pop
);

    payload_t                  mem [tlk_pkg::BUF_DEPTH];
    logic [tlk_pkg::PTR_W-1:0] wr_ptr;
    logic [tlk_pkg::PTR_W-1:0] rd_ptr;
    logic                      do_push;
    logic                      do_pop;

    assign do_push = i_push && !o_full;   // push on full is lost
    assign do_pop  = i_pop && !o_empty;

    assign o_full  = (o_count == tlk_pkg::CNT_W'(tlk_pkg::BUF_DEPTH));
    assign o_empty = (o_count == '0);
    assign o_data  = mem[rd_ptr];         // lookahead read

    // pointers wrap on their own, depth is a power of 2
    always_ff @(posedge clk_80) begin
        if (rst_80) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            o_count  <= '0;
            o_credit <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            o_count  <= o_count + tlk_pkg::CNT_W'(do_push) - tlk_pkg::CNT_W'(do_pop);
            o_credit <= do_pop;            // returned to the producer next cycle
        end
    end

    // storage
    always_ff @(posedge clk_80) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

endmodule

/* logic/tlk_pkg.sv */
// tlk_pkg: buffer sizes, register map, link control words, receive payload type
package tlk_pkg;

    // buffer sizes, one shared depth since a single fifo module serves both sides
    localparam int TX_DEPTH  = 16;
    localparam int RX_DEPTH  = 16;
    localparam int BUF_DEPTH = (TX_DEPTH > RX_DEPTH) ? TX_DEPTH : RX_DEPTH; // power of 2
    localparam int PTR_W     = $clog2(BUF_DEPTH);
    localparam int CNT_W     = $clog2(BUF_DEPTH + 1);   // also frame length width
    localparam int CRED_W    = 8;                       // host rx credit counter

    // register port and link widths
    localparam int REG_DW = 64;
    localparam int REG_AW = 16;
    localparam int WORD_W = 16;

    // register map, unmapped addresses read 0
    localparam logic [REG_AW-1:0] ADDR_CTRL       = 16'd0; // b0 link en, b1 loopen, b2 tx en
    localparam logic [REG_AW-1:0] ADDR_FRAME_LEN  = 16'd1;
    localparam logic [REG_AW-1:0] ADDR_IRQ_STATUS = 16'd2; // w1c: b0 tx, b1 rx, b2 loss
    localparam logic [REG_AW-1:0] ADDR_IRQ_MASK   = 16'd3;
    localparam logic [REG_AW-1:0] ADDR_TX_FRAMES  = 16'd4;
    localparam logic [REG_AW-1:0] ADDR_RX_FRAMES  = 16'd5;
    localparam logic [REG_AW-1:0] ADDR_ERRORS     = 16'd6;

    // link control words
    localparam logic [WORD_W-1:0] IDLE_WORD = 16'hC5BC; // tklsb only
    localparam logic [WORD_W-1:0] SOF_WORD  = 16'hFBFB; // both k flags
    localparam logic [WORD_W-1:0] EOF_WORD  = 16'hFDFD; // both k flags

    // receive payload, data plus end-of-frame marker
    typedef struct packed {
        logic [WORD_W-1:0] data;
        logic              last;
    } rx_word_t;

endpackage
